/* sim/access_cases.txt */
# port we addr be wdata rdata illegal pair hold (hex for addr be wdata rdata)
# pair set runs the wb line against the next dmem line, hold is cycles with wb enable low
wb   1 30000010 f 11223344 00000000 0 0 0
wb   0 30000010 f 00000000 11223344 0 0 0
wb   1 30000020 f a5a5a5a5 00000000 0 0 0
wb   1 30000020 5 00ff00ff 00000000 0 0 0
wb   0 30000020 f 00000000 a5ffa5ff 0 0 0
dmem 1 80000040 f cafef00d 00000000 0 0 0
wb   0 30000040 f 00000000 cafef00d 0 0 0
wb   1 30000044 f 0badbeef 00000000 0 0 0
dmem 0 80000044 f 00000000 0badbeef 0 0 0
dmem 1 80000044 2 0000aa00 00000000 0 0 0
wb   0 30000044 f 00000000 0badaaef 0 0 0
wb   1 70000048 f 13579bdf 00000000 0 0 0
dmem 0 80000048 f 00000000 13579bdf 0 0 0
wb   1 30000050 f 5555aaaa 00000000 0 1 0
dmem 1 80000054 f 6666bbbb 00000000 0 0 0
wb   0 30000054 f 00000000 6666bbbb 0 1 0
dmem 0 80000050 f 00000000 5555aaaa 0 0 0
wb   1 30000000 f 01020304 00000000 0 0 0
dmem 1 80000ffc f 89abcdef 00000000 0 0 0
wb   1 30001000 f deadbeef 00000000 1 0 0
dmem 1 7ffffffc f ffffffff 00000000 1 0 0
wb   0 30000000 f 00000000 01020304 0 0 0
wb   0 30000ffc f 00000000 89abcdef 0 0 0
dmem 0 80001000 f 00000000 00000000 1 0 0
wb   0 20000000 f 00000000 00000000 1 0 0
wb   1 30000060 f 76543210 00000000 0 0 5
wb   0 30000060 f 00000000 76543210 0 0 3

/* clam_sram_soc.f */
+incdir+common
common/sram_soc_pkg.sv
wb_bridge/wb_obi_bridge.sv
verilog/obi_priority_mux.sv
sram/sram_bank.sv
verilog/sram_subsystem.sv
sim/tb_sram_subsystem.sv

/* sim/tb_sram_subsystem.sv */
`timescale 1ns/10ps

module tb_sram_subsystem;

    // One line of the case file
    typedef struct packed {
        logic                is_wb;
        logic                we;
        sram_soc_pkg::addr_t addr;
        sram_soc_pkg::be_t   be;
        sram_soc_pkg::data_t wdata;
        sram_soc_pkg::data_t exp_rdata;
        logic                exp_ill;
        logic                pair;
        logic [7:0]          hold;
    } access_case_t;

    logic                   clk_i;
    logic                   rst_i;
    sram_soc_pkg::wb_req_t  wbs_i;
    logic                   wb_enable_i;
    logic                   wbs_ack_o;
    sram_soc_pkg::data_t    wbs_dat_o;
    sram_soc_pkg::obi_req_t dmem_i;
    sram_soc_pkg::obi_rsp_t dmem_o;
    logic                   illegal_o;

    access_case_t cases [64];
    int           num_cases;
    int           cycle_count;
    int           cycle_limit;
    logic         dmem_busy;

    sram_subsystem i_sram_subsystem (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wbs_i       (wbs_i),
        .wb_enable_i (wb_enable_i),
        .wbs_ack_o   (wbs_ack_o),
        .wbs_dat_o   (wbs_dat_o),
        .dmem_i      (dmem_i),
        .dmem_o      (dmem_o),
        .illegal_o   (illegal_o)
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, a transfer never completed", cycle_count);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    // Responses that belong to no running transfer
    always @(negedge clk_i) begin
        if (!rst_i) begin
            check_value(wbs_ack_o && !wbs_i.cyc, 1'b0, "Wishbone ack outside a cycle");
            check_value(dmem_o.rvalid && !dmem_busy, 1'b0, "dmem rvalid with no transfer");
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "check mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Case file
    ////////////////////////////////////////////////////////////

    task automatic load_cases();
        int               fd;
        int               fields;
        int               we;
        int               ill;
        int               pair;
        int               hold;
        logic [63:0]      port_name;
        logic [8*160-1:0] line;
        logic [31:0]      addr;
        logic [31:0]      be;
        logic [31:0]      wdata;
        logic [31:0]      rdata;

        num_cases = 0;
        fd = $fopen("sim/access_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file sim/access_cases.txt");
            $display("Testbench failed");
            $fatal(1, "missing case file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Comment lines stop after the first field
                fields = $sscanf(line, "%s %d %h %h %h %h %d %d %d", port_name, we, addr,
                                 be, wdata, rdata, ill, pair, hold);
                if (fields == 9) begin
                    cases[num_cases].is_wb     = (port_name == "wb");
                    cases[num_cases].we        = we[0];
                    cases[num_cases].addr      = addr;
                    cases[num_cases].be        = be[3:0];
                    cases[num_cases].wdata     = wdata;
                    cases[num_cases].exp_rdata = rdata;
                    cases[num_cases].exp_ill   = ill[0];
                    cases[num_cases].pair      = pair[0];
                    cases[num_cases].hold      = hold[7:0];
                    num_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Transfers on the two ports
    ////////////////////////////////////////////////////////////

    task automatic wb_access(input access_case_t c, output sram_soc_pkg::data_t rdata,
                             output logic ill);
        logic ill_prev;

        ill_prev = 1'b0;
        @(posedge clk_i);
        #10;
        wbs_i.cyc   = 1'b1;
        wbs_i.stb   = 1'b1;
        wbs_i.we    = c.we;
        wbs_i.sel   = c.be;
        wbs_i.adr   = c.addr;
        wbs_i.dat   = c.wdata;
        wb_enable_i = (c.hold == 0);
        // No ack may come while the host path is disabled
        repeat (c.hold) begin
            @(negedge clk_i);
            check_value(wbs_ack_o, 1'b0, "Wishbone ack while the enable is low");
            @(posedge clk_i);
            #10;
        end
        wb_enable_i = 1'b1;
        @(negedge clk_i);
        while (wbs_ack_o !== 1'b1) begin
            ill_prev = illegal_o;
            @(negedge clk_i);
        end
        // illegal_o rides with rvalid one cycle ahead of ack
        rdata = wbs_dat_o;
        ill   = ill_prev;
        @(posedge clk_i);
        #10;
        wbs_i = '0;
    endtask

    task automatic dmem_access(input access_case_t c, input int delay,
                               output sram_soc_pkg::data_t rdata, output logic ill,
                               output int stalls);
        stalls = 0;
        repeat (delay) @(posedge clk_i);
        @(posedge clk_i);
        #10;
        dmem_busy    = 1'b1;
        dmem_i.req   = 1'b1;
        dmem_i.we    = c.we;
        dmem_i.be    = c.be;
        dmem_i.addr  = c.addr;
        dmem_i.wdata = c.wdata;
        @(negedge clk_i);
        check_value(dmem_o.rvalid, 1'b0, "dmem rvalid before its own response");
        while (dmem_o.gnt !== 1'b1) begin
            stalls++;
            @(negedge clk_i);
            check_value(dmem_o.rvalid, 1'b0, "dmem rvalid before its own response");
        end
        @(posedge clk_i);
        #10;
        dmem_i = '0;
        @(negedge clk_i);
        check_value(dmem_o.rvalid, 1'b1, "dmem rvalid one cycle after acceptance");
        rdata = dmem_o.rdata;
        ill   = illegal_o;
        @(posedge clk_i);
        #10;
        dmem_busy = 1'b0;
    endtask

    task automatic compare_response(input access_case_t c, input sram_soc_pkg::data_t rdata,
                                    input logic ill);
        check_value(rdata, c.exp_rdata, $sformatf("read data for address %h", c.addr));
        check_value(ill, c.exp_ill, $sformatf("illegal flag for address %h", c.addr));
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin : stimulus
        access_case_t        cur;
        access_case_t        partner;
        sram_soc_pkg::data_t wb_rdata;
        sram_soc_pkg::data_t dm_rdata;
        logic                wb_ill;
        logic                dm_ill;
        int                  stalls;
        int                  seed;
        int                  idx;

        seed = 32'h65c6;
        void'($urandom(seed));
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        wbs_i       = '0;
        wb_enable_i = 1'b1;
        dmem_i      = '0;
        dmem_busy   = 1'b0;
        cycle_count = 0;
        cycle_limit = 0;
        load_cases();
        cycle_limit = 40 * num_cases + 20;

        repeat (5) @(posedge clk_i);
        #10;
        rst_i = 1'b0;
        @(negedge clk_i);
        check_value(wbs_ack_o, 1'b0, "Wishbone ack after reset");
        check_value(dmem_o.gnt, 1'b0, "dmem gnt after reset");
        check_value(dmem_o.rvalid, 1'b0, "dmem rvalid after reset");
        check_value(illegal_o, 1'b0, "illegal flag after reset");

        idx = 0;
        while (idx < num_cases) begin
            cur = cases[idx];
            if (cur.pair) begin
                partner = cases[idx + 1];
                check_value({cur.is_wb, partner.is_wb}, 2'b10, "pair is not wb then dmem");
                // Bridge req rises a cycle after stb and dmem joins in that cycle
                fork
                    wb_access(cur, wb_rdata, wb_ill);
                    dmem_access(partner, 1, dm_rdata, dm_ill, stalls);
                join
                compare_response(cur, wb_rdata, wb_ill);
                compare_response(partner, dm_rdata, dm_ill);
                check_value(stalls, 1, "dmem cycles without gnt under contention");
                idx += 2;
            end else if (cur.is_wb) begin
                wb_access(cur, wb_rdata, wb_ill);
                compare_response(cur, wb_rdata, wb_ill);
                idx++;
            end else begin
                dmem_access(cur, 0, dm_rdata, dm_ill, stalls);
                compare_response(cur, dm_rdata, dm_ill);
                check_value(stalls, 0, "dmem cycles without gnt, no contention");
                idx++;
            end
            repeat ($urandom % 3) @(posedge clk_i);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

/* verilog/sram_subsystem.sv */
`timescale 1ns/10ps

module sram_subsystem (
    input  logic                   clk_i,
    input  logic                   rst_i,

    // Wishbone host
    input  sram_soc_pkg::wb_req_t  wbs_i,
    input  logic                   wb_enable_i,
    output logic                   wbs_ack_o,
    output sram_soc_pkg::data_t    wbs_dat_o,

    // Core data port
    input  sram_soc_pkg::obi_req_t dmem_i,
    output sram_soc_pkg::obi_rsp_t dmem_o,

    output logic                   illegal_o
);

    // Bridge to multiplexer
    sram_soc_pkg::obi_req_t bridge_req;
    sram_soc_pkg::obi_rsp_t bridge_rsp;

    // Multiplexer to SRAM bank
    sram_soc_pkg::obi_req_t sram_req;
    sram_soc_pkg::obi_rsp_t sram_rsp;

    ////////////////////////////////////////////////////////////
    // Host bridge
    ////////////////////////////////////////////////////////////

    wb_obi_bridge i_wb_obi_bridge (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wbs_i       (wbs_i),
        .wb_enable_i (wb_enable_i),
        .obi_rsp_i   (bridge_rsp),
        .obi_req_o   (bridge_req),
        .wbs_ack_o   (wbs_ack_o),
        .wbs_dat_o   (wbs_dat_o)
    );

    ////////////////////////////////////////////////////////////
    // Arbitration of host over core
    ////////////////////////////////////////////////////////////

    obi_priority_mux i_obi_priority_mux (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .pri_req_i (bridge_req),
        .pri_rsp_o (bridge_rsp),
        .sec_req_i (dmem_i),
        .sec_rsp_o (dmem_o),
        .shr_req_o (sram_req),
        .shr_rsp_i (sram_rsp)
    );

    // Shared SRAM
    sram_bank i_sram_bank (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .obi_req_i (sram_req),
        .obi_rsp_o (sram_rsp),
        .illegal_o (illegal_o)
    );

endmodule

/* sram/sram_bank.sv */
`timescale 1ns/10ps

`include "sram_soc_settings.svh"

module sram_bank (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  sram_soc_pkg::obi_req_t obi_req_i,
    output sram_soc_pkg::obi_rsp_t obi_rsp_o,
    output logic                   illegal_o
);

    // Storage array
    sram_soc_pkg::data_t mem [`SRAM_WORDS];

    sram_soc_pkg::addr_t    offset;
    logic [`SRAM_IDX_W-1:0] word_idx;
    logic                   in_window;
    logic                   wr_en;
    logic                   rd_en;

    logic                rvalid_q;
    logic                illegal_q;
    sram_soc_pkg::data_t rdata_q;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    assign offset   = obi_req_i.addr - `SRAM_BASE;
    assign word_idx = offset[`SRAM_IDX_W+1:2];

    // Inside when the byte offset fits in SRAM_WORDS words
    assign in_window = (obi_req_i.addr >= `SRAM_BASE) &&
                       (offset[`SOC_ADDR_W-1:`SRAM_IDX_W+2] == '0);

    assign wr_en = obi_req_i.req && obi_req_i.we && in_window;
    assign rd_en = obi_req_i.req && !obi_req_i.we && in_window;

    ////////////////////////////////////////////////////////////
    // Array access
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            for (int b = 0; b < `SOC_BE_W; b++) begin
                if (obi_req_i.be[b]) begin
                    mem[word_idx][b*8 +: 8] <= obi_req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Writes and out-of-window reads return zero
    always_ff @(posedge clk_i) begin
        if (obi_req_i.req) begin
            rdata_q <= rd_en ? mem[word_idx] : '0;
        end
    end

    // Response one cycle after acceptance
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rvalid_q  <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            rvalid_q  <= obi_req_i.req;
            illegal_q <= obi_req_i.req && !in_window;
        end
    end

    // every request is granted right away
    assign obi_rsp_o.gnt    = obi_req_i.req;
    assign obi_rsp_o.rvalid = rvalid_q;
    assign obi_rsp_o.rdata  = rdata_q;

    assign illegal_o = illegal_q;

endmodule

/* verilog/obi_priority_mux.sv */
`timescale 1ns/10ps

module obi_priority_mux (
    input  logic                   clk_i,
    input  logic                   rst_i,

    // Primary side that always wins
    input  sram_soc_pkg::obi_req_t pri_req_i,
    output sram_soc_pkg::obi_rsp_t pri_rsp_o,

    // Secondary side
    input  sram_soc_pkg::obi_req_t sec_req_i,
    output sram_soc_pkg::obi_rsp_t sec_rsp_o,

    // Shared responder
    output sram_soc_pkg::obi_req_t shr_req_o,
    input  sram_soc_pkg::obi_rsp_t shr_rsp_i
);

    logic pri_sel;
    logic shr_accept;

    // Set when the last accepted transfer came from the primary side
    logic owner_pri_q;

    ////////////////////////////////////////////////////////////
    // Request path
    ////////////////////////////////////////////////////////////

    assign pri_sel = pri_req_i.req;

    // The whole request follows the winner
    assign shr_req_o = pri_sel ? pri_req_i : sec_req_i;

    assign shr_accept = shr_req_o.req && shr_rsp_i.gnt;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            owner_pri_q <= 1'b0;
        end else if (shr_accept) begin
            owner_pri_q <= pri_sel;
        end
    end

    ////////////////////////////////////////////////////////////
    // Response path
    ////////////////////////////////////////////////////////////

    always_comb begin
        // gnt only to the side that is selected this cycle
        pri_rsp_o.gnt = pri_sel && shr_rsp_i.gnt;
        sec_rsp_o.gnt = !pri_sel && sec_req_i.req && shr_rsp_i.gnt;

        // rvalid belongs to the transfer accepted one cycle earlier
        pri_rsp_o.rvalid = shr_rsp_i.rvalid && owner_pri_q;
        sec_rsp_o.rvalid = shr_rsp_i.rvalid && !owner_pri_q;

        if (owner_pri_q) begin
            pri_rsp_o.rdata = shr_rsp_i.rdata;
            sec_rsp_o.rdata = '0;
        end else begin
            pri_rsp_o.rdata = '0;
            sec_rsp_o.rdata = shr_rsp_i.rdata;
        end
    end

endmodule

/* wb_bridge/wb_obi_bridge.sv */
`timescale 1ns/10ps

`include "sram_soc_settings.svh"

module wb_obi_bridge (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  sram_soc_pkg::wb_req_t  wbs_i,
    input  logic                   wb_enable_i,
    input  sram_soc_pkg::obi_rsp_t obi_rsp_i,
    output sram_soc_pkg::obi_req_t obi_req_o,
    output logic                   wbs_ack_o,
    output sram_soc_pkg::data_t    wbs_dat_o
);

    sram_soc_pkg::bridge_state_e state_q;
    sram_soc_pkg::bridge_state_e state_d;

    // Wishbone fields held for the whole OBI transfer
    logic                we_q;
    sram_soc_pkg::be_t   sel_q;
    sram_soc_pkg::addr_t adr_q;
    sram_soc_pkg::data_t dat_q;

    // Read data waiting for the ack pulse
    sram_soc_pkg::data_t rdata_q;

    sram_soc_pkg::addr_t remap_addr;
    logic                wb_start;
    logic                obi_accept;

    assign wb_start   = wbs_i.cyc && wbs_i.stb;
    assign obi_accept = obi_req_o.req && obi_rsp_i.gnt;

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            sram_soc_pkg::IDLE: begin
                if (wb_start) begin
                    state_d = sram_soc_pkg::REQUEST;
                end
            end
            sram_soc_pkg::REQUEST: begin
                // Stays here with req low while the host path is disabled
                if (obi_accept) begin
                    state_d = sram_soc_pkg::WAIT_RSP;
                end
            end
            sram_soc_pkg::WAIT_RSP: begin
                if (obi_rsp_i.rvalid) begin
                    state_d = sram_soc_pkg::ACK;
                end
            end
            sram_soc_pkg::ACK: begin
                state_d = sram_soc_pkg::IDLE;
            end
            default: begin
                state_d = sram_soc_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= sram_soc_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // Captured request and response
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (state_q == sram_soc_pkg::IDLE && wb_start) begin
            we_q  <= wbs_i.we;
            sel_q <= wbs_i.sel;
            adr_q <= wbs_i.adr;
            dat_q <= wbs_i.dat;
        end
        if (state_q == sram_soc_pkg::WAIT_RSP && obi_rsp_i.rvalid) begin
            rdata_q <= obi_rsp_i.rdata;
        end
    end

    // 0x3xxx_xxxx to 0x7xxx_xxxx lands in the SRAM window
    always_comb begin
        if (adr_q >= `WB_REMAP_LO && adr_q < `WB_REMAP_HI) begin
            remap_addr = {`WB_REMAP_NIBBLE, adr_q[`SOC_ADDR_W-5:0]};
        end else begin
            remap_addr = adr_q;
        end
    end

    always_comb begin
        obi_req_o.req   = (state_q == sram_soc_pkg::REQUEST) && wb_enable_i;
        obi_req_o.we    = we_q;
        obi_req_o.be    = sel_q;
        obi_req_o.addr  = remap_addr;
        obi_req_o.wdata = dat_q;
    end

    // One-cycle ack with the captured word
    assign wbs_ack_o = (state_q == sram_soc_pkg::ACK);
    assign wbs_dat_o = rdata_q;

endmodule

/* common/sram_soc_pkg.sv */
`include "sram_soc_settings.svh"

package sram_soc_pkg;

    ////////////////////////////////////////////////////////////
    // Plain vector types
    ////////////////////////////////////////////////////////////

    typedef logic [`SOC_ADDR_W-1:0] addr_t;
    typedef logic [`SOC_DATA_W-1:0] data_t;
    typedef logic [`SOC_BE_W-1:0]   be_t;

    ////////////////////////////////////////////////////////////
    // OBI bus
    ////////////////////////////////////////////////////////////

    // Requester to responder
    typedef struct packed {
        logic  req;
        logic  we;
        be_t   be;
        addr_t addr;
        data_t wdata;
    } obi_req_t;

    // Responder to requester with rdata valid only alongside rvalid
    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        data_t rdata;
    } obi_rsp_t;

    ////////////////////////////////////////////////////////////
    // Wishbone slave inputs
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        be_t   sel;
        addr_t adr;
        data_t dat;
    } wb_req_t;

    // Bridge FSM states
    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT_RSP,
        ACK
    } bridge_state_e;

endpackage

/* common/sram_soc_settings.svh */
`ifndef SRAM_SOC_SETTINGS_SVH
`define SRAM_SOC_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////

`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_BE_W 4

// SRAM window of one word per index
`define SRAM_BASE 32'h8000_0000
`define SRAM_WORDS 1024
`define SRAM_IDX_W 10

////////////////////////////////////////////////////////////
// Host address remap window
////////////////////////////////////////////////////////////

`define WB_REMAP_LO 32'h3000_0000
`define WB_REMAP_HI 32'h8000_0000
`define WB_REMAP_NIBBLE 4'h8

`endif
